/* cache_top.f */
+incdir+.
cache_pkg.sv
cache_access_decode.sv
cache_tag_lru.sv
cache_data_array.sv
cache_load_align.sv
cache_top.sv
cache_assert.sv
cache_tb.sv

/* run.sh */
#!/bin/sh
# builds cache_tb with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module cache_tb \
    -f cache_top.f -o cache_sim || { echo "build failed"; exit 1; }
result=$(./obj_dir/cache_sim)
echo "$result"
echo "$result" | grep -qx "All tests passed" && echo "run ok" || { echo "run failed"; exit 1; }

/* cache_tb.sv */
// self-checking testbench for cache_top against a behavioral model of the cache
// tags and data are unknown until every word is filled, dout and tag are checked after that
`timescale 1ns/10ps

module cache_tb;

    typedef struct packed {
        logic             hit;
        logic             valid;
        logic             dirty;
        cache_pkg::tag_t  tag;
        cache_pkg::word_t dout;
    } expect_t;

    localparam logic [3:0] op_load  = 4'b1000;  // {load, store, replace, invalid}
    localparam logic [3:0] op_store = 4'b0100;
    localparam logic [3:0] op_repl  = 4'b0010;
    localparam logic [3:0] op_inv   = 4'b0001;
    localparam logic [3:0] op_idle  = 4'b0000;
    // reset, probe, fill, invalidate, directed, random
    localparam int test_cycles = 2 + 16 + 256 + 16 + 60 + 400;

    logic             clk = 1'b0;
    logic             arst_n;
    cache_pkg::addr_t addr;
    logic             load, store, replace, invalid;
    logic [2:0]       size_code;
    cache_pkg::word_t din;
    logic             hit, valid, dirty;
    cache_pkg::word_t dout;
    cache_pkg::tag_t  tag;

    // model state, line index is set*4+way, word index line*4+word
    logic             m_valid [64];
    logic             m_dirty [64];
    cache_pkg::tag_t  m_tag [64];
    cache_pkg::lru_t  m_age [64];
    cache_pkg::word_t m_data [256];
    logic             full_check = 1'b0;
    int               errors = 0;
    int               checks = 0;
    integer           seed = 32'h3e189799;

    cache_top dut_i (
        .clk(clk), .arst_n(arst_n), .addr(addr), .load(load), .store(store),
        .replace(replace), .invalid(invalid), .size_code(size_code), .din(din),
        .hit(hit), .dout(dout), .valid(valid), .dirty(dirty), .tag(tag)
    );

    always #10 clk = ~clk;

    // {hit, way}: the way holding the tag, else the oldest, lowest number on a tie
    function automatic logic [2:0] find_way(cache_pkg::set_idx_t s, cache_pkg::tag_t t);
        int best;
        best = 0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[s*4+w] && m_tag[s*4+w] === t) return {1'b1, 2'(w)};
        end
        for (int w = 1; w < 4; w++) begin
            if (m_age[s*4+w] > m_age[s*4+best]) best = w;
        end
        return {1'b0, 2'(best)};
    endfunction

    function automatic expect_t predict(cache_pkg::addr_t a, logic [2:0] sc, logic ld);
        expect_t          e;
        logic [2:0]       hw;
        int               line;
        cache_pkg::word_t w;
        logic [15:0]      h;
        logic [7:0]       b;
        hw = find_way(a[7:4], a[31:8]);
        line = a[7:4] * 4 + hw[1:0];
        w = m_data[line * 4 + a[3:2]];
        h = a[1] ? w[31:16] : w[15:0];
        b = 8'(w >> (8 * a[1:0]));
        e.hit = hw[2];
        e.valid = m_valid[line];
        e.dirty = m_dirty[line];
        e.tag = m_tag[line];
        e.dout = w;  // raw word unless a load hits
        if (ld && hw[2] && !sc[1]) begin
            if (sc[0]) e.dout = sc[2] ? {16'h0, h} : {{16{h[15]}}, h};
            else e.dout = sc[2] ? {24'h0, b} : {{24{b[7]}}, b};
        end
        return e;
    endfunction

    function automatic void update_model(cache_pkg::addr_t a, logic [2:0] sc, logic ld,
                                         logic st, logic rp, logic inv, cache_pkg::word_t d);
        logic [2:0]      hw;
        int              base;
        int              line;
        int              widx;
        cache_pkg::lru_t old_age;
        hw = find_way(a[7:4], a[31:8]);
        base = a[7:4] * 4;
        line = base + hw[1:0];
        widx = line * 4 + a[3:2];
        old_age = m_age[line];
        for (int w = 0; w < 4; w++) begin
            if (inv) begin
                m_valid[base+w] = 1'b0;
                m_dirty[base+w] = 1'b0;
                m_age[base+w] = '0;
            end else if (ld || rp || (st && hw[2])) begin
                if (base + w == line) m_age[base+w] = '0;
                else if (m_age[base+w] <= old_age) m_age[base+w] = m_age[base+w] + 1'b1;
            end
        end
        if (rp) begin
            m_valid[line] = 1'b1;
            m_dirty[line] = 1'b0;
            m_tag[line] = a[31:8];
            m_data[widx] = d;
        end else if (st && hw[2]) begin
            m_dirty[line] = 1'b1;
            if (sc[1]) m_data[widx] = d;
            else if (sc[0] && a[1]) m_data[widx][31:16] = d[15:0];
            else if (sc[0]) m_data[widx][15:0] = d[15:0];
            else m_data[widx][8*a[1:0] +: 8] = d[7:0];
        end
    endfunction

    task automatic check_word(string name, cache_pkg::word_t got, cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(string name, cache_pkg::tag_t got, cache_pkg::tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs are settled mid-cycle, state moves on the next rising edge
    always @(negedge clk) begin : compare
        expect_t e;
        if (!arst_n) begin
            for (int i = 0; i < 64; i++) begin
                m_valid[i] = 1'b0;
                m_dirty[i] = 1'b0;
                m_age[i] = '0;
            end
        end else begin
            e = predict(addr, size_code, load);
            check_bit("hit", hit, e.hit);
            check_bit("valid", valid, e.valid);
            check_bit("dirty", dirty, e.dirty);
            if (full_check) begin
                check_tag("tag", tag, e.tag);
                check_word("dout", dout, e.dout);
            end
            update_model(addr, size_code, load, store, replace, invalid, din);
        end
    end

    function automatic cache_pkg::addr_t make_addr(int t, int s, int w, int b);
        return cache_pkg::addr_t'((t << 8) + (s << 4) + (w << 2) + b);
    endfunction

    function automatic cache_pkg::word_t fill_word(cache_pkg::addr_t a);
        return {a[7:0], a[15:8], a[23:16], a[31:24]} ^ 32'h9e3779b9;
    endfunction

    task automatic drive(cache_pkg::addr_t a, logic [2:0] sc, logic [3:0] op,
                         cache_pkg::word_t d);
        @(posedge clk);
        addr <= a;
        size_code <= sc;
        din <= d;
        {load, store, replace, invalid} <= op;
    endtask

    initial begin : stimulus
        int               r;
        int               k;
        logic [3:0]       op;
        cache_pkg::addr_t a;
        arst_n = 1'b0;
        addr = '0;
        size_code = '0;
        din = '0;
        {load, store, replace, invalid} = op_idle;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < 16; i++) begin  // nothing valid after reset
            r = $random(seed);
            drive(cache_pkg::addr_t'(r), 3'b010, op_idle, '0);
        end
        // four tags per set, every word written once
        for (int s = 0; s < 16; s++) begin
            for (int t = 0; t < 4; t++) begin
                for (int w = 0; w < 4; w++) begin
                    a = make_addr(24'hf00 + t, s, w, 0);
                    drive(a, 3'b010, op_repl, fill_word(a));
                end
            end
        end
        for (int s = 0; s < 16; s++) begin
            drive(make_addr(0, s, 0, 0), 3'b010, op_inv, '0);
            full_check = 1'b1;
        end
        // replace, load back, then partial stores and every load size and offset
        a = make_addr(24'h3c5a17, 3, 1, 0);
        drive(a, 3'b010, op_repl, 32'h8e6bf0a4);
        drive(a, 3'b010, op_load, '0);
        drive(a, 3'b000, op_store, 32'h000000c3);
        drive(a + 2, 3'b001, op_store, 32'h000091e7);
        for (int b = 0; b < 4; b++) begin
            for (int c = 0; c < 8; c++) drive(a + b, 3'(c), op_load, '0);
        end
        drive(make_addr(24'h777777, 3, 1, 0), 3'b010, op_store, 32'hffffffff);  // miss
        drive(a, 3'b010, op_load, '0);
        // five tags into set 9, the dirty first one gets evicted
        for (int t = 0; t < 4; t++) drive(make_addr(24'h0a0 + t, 9, 2, 0), 3'b010, op_repl, $random(seed));
        drive(make_addr(24'h0a0, 9, 2, 1), 3'b000, op_store, 32'h00000055);
        for (int t = 1; t < 4; t++) drive(make_addr(24'h0a0 + t, 9, 2, 0), 3'b010, op_load, '0);
        drive(make_addr(24'h0a4, 9, 2, 0), 3'b010, op_idle, '0);
        drive(make_addr(24'h0a4, 9, 2, 0), 3'b010, op_repl, 32'h13572468);
        drive(make_addr(24'h0a4, 9, 2, 0), 3'b010, op_load, '0);
        // invalidate set 9 only
        drive(make_addr(0, 9, 0, 0), 3'b010, op_inv, '0);
        for (int t = 1; t < 5; t++) drive(make_addr(24'h0a0 + t, 9, 2, 0), 3'b010, op_load, '0);
        drive(a, 3'b010, op_load, '0);
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            k = (r >> 9) & 15;
            if (k == 0) op = op_inv;
            else if (k < 6) op = op_load;
            else if (k < 10) op = op_store;
            else if (k < 14) op = op_repl;
            else op = op_idle;
            a = make_addr(24'h5a0 + ((r & 7) % 5), ((r >> 3) & 3) * 4 + 1, (r >> 5) & 3,
                          (r >> 7) & 3);
            drive(a, 3'(r >> 13), op, $random(seed));
        end
        drive(a, 3'b010, op_idle, '0);
        @(negedge clk);
        #1;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(test_cycles * 20 + 1000);
        $display("timeout, stimulus did not finish within %0d cycles", test_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* cache_assert.sv */
// protocol and output checks, bound into every cache_top
// inactive while arst_n is low
`timescale 1ns/10ps

module cache_assert (
    input logic             clk,
    input logic             arst_n,
    input cache_pkg::addr_t addr,
    input logic             load,
    input logic             store,
    input logic             replace,
    input logic             invalid,
    input logic             hit,
    input logic             valid,
    input logic             dirty,
    input cache_pkg::word_t dout
);

    one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({load, store, replace, invalid}))
        else $error("more than one operation strobe in the same cycle");

    // a line just replaced hits clean when the same address follows
    hit_after_replace: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(replace) && addr == $past(addr)) |-> (hit && valid && !dirty))
        else $error("replaced address does not hit as a valid clean line");

    // unwritten words read as X, a load hit never does
    dout_known: assert property (@(posedge clk) disable iff (!arst_n)
        (load && hit) |-> !$isunknown(dout))
        else $error("dout has unknown bits on a load hit");

endmodule

bind cache_top cache_assert assert_i (
    .clk(clk), .arst_n(arst_n), .addr(addr), .load(load), .store(store),
    .replace(replace), .invalid(invalid), .hit(hit), .valid(valid), .dirty(dirty),
    .dout(dout)
);

/* cache_top.sv */
// four-way set-associative cache array, 16 sets, four words per line
// outputs are combinational from addr and stored state; one strobe per cycle at most
`timescale 1ns/10ps

module cache_top (
    input  logic              clk,
    input  logic              arst_n,
    input  cache_pkg::addr_t  addr,
    input  logic              load,
    input  logic              store,
    input  logic              replace,
    input  logic              invalid,
    input  logic [2:0]        size_code,
    input  cache_pkg::word_t  din,
    output logic              hit,
    output cache_pkg::word_t  dout,
    output logic              valid,
    output logic              dirty,
    output cache_pkg::tag_t   tag
);

    cache_pkg::set_idx_t     set_idx;
    cache_pkg::tag_t         addr_tag;
    cache_pkg::word_sel_t    word_sel;
    cache_pkg::byte_sel_t    byte_sel;
    cache_pkg::access_size_e size;
    logic                    is_unsigned;
    cache_pkg::byte_en_t     byte_en;
    cache_pkg::word_t        wdata;
    cache_pkg::way_t         sel_way;
    logic                    data_we;
    cache_pkg::word_t        rdata;

    cache_access_decode decode_i (
        .addr        (addr),
        .size_code   (size_code),
        .store       (store),
        .replace     (replace),
        .din         (din),
        .set_idx     (set_idx),
        .addr_tag    (addr_tag),
        .word_sel    (word_sel),
        .byte_sel    (byte_sel),
        .size        (size),
        .is_unsigned (is_unsigned),
        .byte_en     (byte_en),
        .wdata       (wdata)
    );

    cache_tag_lru tag_lru_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .set_idx  (set_idx),
        .addr_tag (addr_tag),
        .load     (load),
        .store    (store),
        .replace  (replace),
        .invalid  (invalid),
        .hit      (hit),
        .sel_way  (sel_way),
        .data_we  (data_we),
        .valid    (valid),
        .dirty    (dirty),
        .tag      (tag)
    );

    cache_data_array data_i (
        .clk      (clk),
        .set_idx  (set_idx),
        .way      (sel_way),  // hit way or victim
        .word_sel (word_sel),
        .data_we  (data_we),
        .byte_en  (byte_en),
        .wdata    (wdata),
        .rdata    (rdata)
    );

    cache_load_align align_i (
        .rdata       (rdata),
        .byte_sel    (byte_sel),
        .size        (size),
        .is_unsigned (is_unsigned),
        .load        (load),
        .hit         (hit),
        .dout        (dout)
    );

endmodule

/* cache_load_align.sv */
// load result shaping, 32-bit words only
// on anything but a load hit the raw word goes out for write-back
`timescale 1ns/10ps

module cache_load_align (
    input  cache_pkg::word_t        rdata,
    input  cache_pkg::byte_sel_t    byte_sel,
    input  cache_pkg::access_size_e size,
    input  logic                    is_unsigned,
    input  logic                    load,
    input  logic                    hit,
    output cache_pkg::word_t        dout
);

    logic [15:0] half_val;
    logic [7:0]  byte_val;
    logic        half_sign;
    logic        byte_sign;

    assign half_val = byte_sel[1] ? rdata[31:16] : rdata[15:0];
    assign byte_val = rdata[8*byte_sel +: 8];

    assign half_sign = !is_unsigned && half_val[15];
    assign byte_sign = !is_unsigned && byte_val[7];

    always_comb begin
        dout = rdata;
        if (load && hit) begin
            case (size)
                cache_pkg::size_byte: dout = {{24{byte_sign}}, byte_val};
                cache_pkg::size_half: dout = {{16{half_sign}}, half_val};
                default:              dout = rdata;
            endcase
        end
    end

endmodule

/* cache_data_array.sv */
// line data, 16 sets x 4 ways x 4 words, no reset
// asynchronous read, byte-lane masked write on the rising edge
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_data_array (
    input  logic                 clk,
    input  cache_pkg::set_idx_t  set_idx,
    input  cache_pkg::way_t      way,
    input  cache_pkg::word_sel_t word_sel,
    input  logic                 data_we,
    input  cache_pkg::byte_en_t  byte_en,
    input  cache_pkg::word_t     wdata,
    output cache_pkg::word_t     rdata
);

    localparam int DEPTH = 1 << (`CACHE_SET_BITS + `CACHE_WAY_BITS + `CACHE_WORD_SEL_BITS);
    localparam int LANES = `CACHE_WORD_BITS / 8;

    cache_pkg::word_t mem [DEPTH];

    logic [`CACHE_SET_BITS+`CACHE_WAY_BITS+`CACHE_WORD_SEL_BITS-1:0] word_idx;

    assign word_idx = {set_idx, way, word_sel};
    assign rdata    = mem[word_idx];

    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int b = 0; b < LANES; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];  // lane already replicated
                end
            end
        end
    end

endmodule

/* cache_tag_lru.sv */
// valid, dirty, tag and age bookkeeping for 16 sets of four ways
// the caller drives at most one strobe per cycle; tags are undefined until first replace
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_tag_lru (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::set_idx_t set_idx,
    input  cache_pkg::tag_t     addr_tag,
    input  logic                load,
    input  logic                store,
    input  logic                replace,
    input  logic                invalid,
    output logic                hit,
    output cache_pkg::way_t     sel_way,
    output logic                data_we,
    output logic                valid,
    output logic                dirty,
    output cache_pkg::tag_t     tag
);

    localparam int LINES = `CACHE_WAYS << `CACHE_SET_BITS;

    // line index is {set, way}
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;
    cache_pkg::lru_t  age_q [LINES];
    cache_pkg::tag_t  tag_q [LINES];

    // view of the addressed set
    logic [`CACHE_WAYS-1:0] set_valid;
    logic [`CACHE_WAYS-1:0] set_dirty;
    logic [`CACHE_WAYS-1:0] way_hit;
    cache_pkg::tag_t        set_tag [`CACHE_WAYS];
    cache_pkg::lru_t        set_age [`CACHE_WAYS];

    cache_pkg::way_t hit_way;
    cache_pkg::way_t victim;
    cache_pkg::lru_t victim_age;
    cache_pkg::lru_t sel_age;
    logic [`CACHE_SET_BITS+`CACHE_WAY_BITS-1:0] sel_line;
    logic touch;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            set_valid[w] = valid_q[{set_idx, cache_pkg::way_t'(w)}];
            set_dirty[w] = dirty_q[{set_idx, cache_pkg::way_t'(w)}];
            set_tag[w]   = tag_q[{set_idx, cache_pkg::way_t'(w)}];
            set_age[w]   = age_q[{set_idx, cache_pkg::way_t'(w)}];
            way_hit[w]   = set_valid[w] && (set_tag[w] == addr_tag);
        end
    end

    // lowest matching way, only one should match anyway
    always_comb begin
        hit_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    // oldest way, ties go to the lower number
    always_comb begin
        victim     = '0;
        victim_age = set_age[0];
        for (int w = 1; w < `CACHE_WAYS; w++) begin
            if (set_age[w] > victim_age) begin
                victim     = cache_pkg::way_t'(w);
                victim_age = set_age[w];
            end
        end
    end

    assign hit      = |way_hit;
    assign sel_way  = hit ? hit_way : victim;
    assign sel_line = {set_idx, sel_way};
    assign sel_age  = set_age[sel_way];

    // write-back report of the selected way
    assign valid = set_valid[sel_way];
    assign dirty = set_dirty[sel_way];
    assign tag   = set_tag[sel_way];

    assign data_we = (store && hit) || replace;
    assign touch   = load || (store && hit) || replace;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            for (int i = 0; i < LINES; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            if (invalid) begin  // drop the whole set
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid_q[{set_idx, cache_pkg::way_t'(w)}] <= 1'b0;
                    dirty_q[{set_idx, cache_pkg::way_t'(w)}] <= 1'b0;
                    age_q[{set_idx, cache_pkg::way_t'(w)}]   <= '0;
                end
            end
            if (touch) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    if (cache_pkg::way_t'(w) == sel_way) begin
                        age_q[{set_idx, cache_pkg::way_t'(w)}] <= '0;
                    end else if (set_age[w] <= sel_age) begin
                        age_q[{set_idx, cache_pkg::way_t'(w)}] <= set_age[w] + 1'b1;
                    end
                end
            end
            if (replace) begin
                valid_q[sel_line] <= 1'b1;
                dirty_q[sel_line] <= 1'b0;
            end
            if (store && hit) begin
                dirty_q[sel_line] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (replace) begin
            tag_q[sel_line] <= addr_tag;
        end
    end

endmodule

/* cache_access_decode.sv */
// address split and access-size decode, purely combinational
// size_code follows the RV32I load funct3 layout: bit 1 word, bit 0 half, bit 2 unsigned
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_access_decode (
    input  cache_pkg::addr_t        addr,
    input  logic [2:0]              size_code,
    input  logic                    store,
    input  logic                    replace,
    input  cache_pkg::word_t        din,
    output cache_pkg::set_idx_t     set_idx,
    output cache_pkg::tag_t         addr_tag,
    output cache_pkg::word_sel_t    word_sel,
    output cache_pkg::byte_sel_t    byte_sel,
    output cache_pkg::access_size_e size,
    output logic                    is_unsigned,
    output cache_pkg::byte_en_t     byte_en,
    output cache_pkg::word_t        wdata
);

    cache_pkg::byte_en_t lane_mask;
    cache_pkg::word_t    lane_data;

    assign addr_tag = addr[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
    assign set_idx  = addr[`CACHE_WORD_SEL_BITS+`CACHE_BYTE_SEL_BITS +: `CACHE_SET_BITS];
    assign word_sel = addr[`CACHE_BYTE_SEL_BITS +: `CACHE_WORD_SEL_BITS];
    assign byte_sel = addr[0 +: `CACHE_BYTE_SEL_BITS];

    assign is_unsigned = size_code[2];

    always_comb begin
        if (size_code[1]) begin  // word wins over half
            size = cache_pkg::size_word;
        end else if (size_code[0]) begin
            size = cache_pkg::size_half;
        end else begin
            size = cache_pkg::size_byte;
        end
    end

    // replicate the store data so every lane of the size carries it
    always_comb begin
        case (size)
            cache_pkg::size_byte: begin
                lane_mask = cache_pkg::byte_en_t'(1) << byte_sel;
                lane_data = {4{din[7:0]}};
            end
            cache_pkg::size_half: begin
                lane_mask = byte_sel[1] ? 4'b1100 : 4'b0011;  // misaligned half uses upper/lower
                lane_data = {2{din[15:0]}};
            end
            default: begin
                lane_mask = '1;
                lane_data = din;
            end
        endcase
    end

    assign byte_en = replace ? '1 : (store ? lane_mask : '0);
    assign wdata   = replace ? din : lane_data;  // replace always writes the whole word

endmodule

/* cache_pkg.sv */
// shared types for the cache array and its testbench
// widths come from cache_defs.svh
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_SET_BITS-1:0] set_idx_t;
    typedef logic [`CACHE_WAY_BITS-1:0] way_t;
    typedef logic [`CACHE_WORD_SEL_BITS-1:0] word_sel_t;
    typedef logic [`CACHE_BYTE_SEL_BITS-1:0] byte_sel_t;
    typedef logic [`CACHE_WORD_BITS-1:0] word_t;

    // one enable per byte lane of a word
    typedef logic [`CACHE_WORD_BITS/8-1:0] byte_en_t;

    typedef logic [`CACHE_LRU_BITS-1:0] lru_t;

    // access width, signedness travels separately
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_e;

endpackage

/* cache_defs.svh */
// geometry of the four-way cache array; the age scheme assumes exactly four ways
// changing a width here also changes every typedef in cache_pkg
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address layout
// tag | set | word | byte
`define CACHE_ADDR_BITS 32
`define CACHE_TAG_BITS 24
`define CACHE_SET_BITS 4
`define CACHE_WORD_SEL_BITS 2
`define CACHE_BYTE_SEL_BITS 2

// associativity
`define CACHE_WAYS 4
`define CACHE_WAY_BITS 2

// payload
`define CACHE_WORD_BITS 32

// per-line age counter, 0 is most recent
`define CACHE_LRU_BITS 2

`endif
